// File: common/arith_defines.svh
`ifndef ARITH_DEFINES_SVH
`define ARITH_DEFINES_SVH

// number of multiplier lanes
`define LANES 4

// carry-save multiplier halves XS and XC
`define WIDTH_X 8

// unsigned coefficient width
`define WIDTH_Y 8

// prefix and compressor structure
// 0 ripple add and linear compressor, 1 serial prefix, 2 sklansky
`define SPEED 2

`endif

// File: common/arithPkg.sv
`include "arith_defines.svh"

package arithPkg;

	// one half of a carry-save multiplier
	typedef logic [`WIDTH_X-1:0] operandX_t;

	typedef logic [`WIDTH_Y-1:0] coef_t; // lane coefficient

	// coefficient bank address
	typedef logic [$clog2(`LANES)-1:0] laneIdx_t;

	typedef logic [`WIDTH_X+`WIDTH_Y-1:0] product_t; // exact lane product

	// room for the carries of all lanes
	typedef logic [`WIDTH_X+`WIDTH_Y+$clog2(`LANES)-1:0] dotSum_t;

endpackage

// File: hw/prefixAdder.sv
`timescale 1ns/100ps

module PrefixAndOr #(
	parameter int width = 8, // word width
	parameter int speed = 2  // 2 sklansky, else serial chain
) (
	input  logic [width-1:0] GI, // bitwise generate
	input  logic [width-1:0] PI, // bitwise propagate
	output logic [width-1:0] GO, // group generate down to bit 0
	output logic [width-1:0] PO  // group propagate down to bit 0
);

	localparam int levels = $clog2(width); // tree depth

	if (speed == 2) begin : sklansky
		logic [levels:0][width-1:0] gT; // one row per level
		logic [levels:0][width-1:0] pT;

		assign gT[0] = GI;
		assign pT[0] = PI;

		for (genvar l = 1; l <= levels; l++) begin : level
			for (genvar i = 0; i < width; i++) begin : node
				// upper half of each block takes the last bit of the lower half
				if (i % (2 ** l) >= 2 ** (l - 1)) begin : black
					localparam int j = (i / (2 ** l)) * (2 ** l) + 2 ** (l - 1) - 1;
					assign gT[l][i] = gT[l-1][i] | (pT[l-1][i] & gT[l-1][j]);
					assign pT[l][i] = pT[l-1][i] & pT[l-1][j];
				end else begin : white
					assign gT[l][i] = gT[l-1][i]; // pass through
					assign pT[l][i] = pT[l-1][i];
				end
			end
		end

		assign GO = gT[levels];
		assign PO = pT[levels];
	end else begin : serial
		logic [width-1:0] gT, pT;

		assign gT[0] = GI[0];
		assign pT[0] = PI[0];

		// one node per bit along the chain
		for (genvar i = 1; i < width; i++) begin : chain
			assign gT[i] = GI[i] | (PI[i] & gT[i-1]);
			assign pT[i] = PI[i] & pT[i-1];
		end

		assign GO = gT;
		assign PO = pT;
	end

endmodule

module Add #(
	parameter int width = 8, // word width
	parameter int speed = 2  // 0 ripple, else prefix
) (
	input  logic [width-1:0] A, // operands
	input  logic [width-1:0] B,
	output logic [width-1:0] S  // sum modulo 2^width
);

	if (speed == 0) begin : ripple
		assign S = A + B; // plain ripple carry
	end else begin : prefix
		logic [width-1:0] gen, prop; // bitwise
		logic [width-1:0] halfSum;   // A xor B
		logic [width-1:0] gGrp;      // carry out of each bit

		assign gen = A & B;
		assign prop = A | B; // or works as propagate beside generate
		assign halfSum = ~gen & prop;

		PrefixAndOr #(
			.width(width),
			.speed(speed)
		) carryTree (
			.GI(gen),
			.PI(prop),
			.GO(gGrp),
			.PO()
		);

		// carry into bit i is the group generate of bit i-1
		assign S = halfSum ^ {gGrp[width-2:0], 1'b0};
	end

endmodule

// File: hw/csvCompressor.sv
`timescale 1ns/100ps

module FullAdder (
	input  logic A,
	input  logic B,
	input  logic CI,
	output logic S,  // weight 1
	output logic CO  // weight 2
);

	logic halfSum;

	assign halfSum = A ^ B;
	assign S = halfSum ^ CI;
	assign CO = (A & B) | (CI & halfSum);

endmodule

module Cpr #(
	parameter int depth = 4, // input bits of one weight
	parameter int speed = 2  // 0 linear chain, else tree
) (
	input  logic [depth-1:0] A,  // bits of this weight
	input  logic [depth-4:0] CI, // intermediate carries from the slice below
	output logic             S,
	output logic             C,
	output logic [depth-4:0] CO  // intermediate carries to the slice above
);

	localparam int fifoW = 3 * depth - 5;

	// inputs first then sum and carry-in pairs as the adders consume them
	logic [fifoW-1:0] fifo;
	logic [depth-3:0] coT;   // carry of every full adder

	assign fifo[depth-1:0] = A;

	// carry-in pair slots
	for (genvar i = 0; i < depth - 3; i++) begin : ciSlot
		assign fifo[depth+2*i+1] = CI[i];
	end

	if (speed == 0) begin : linear
		FullAdder fa0 (
			.A (fifo[0]),
			.B (fifo[1]),
			.CI(fifo[2]),
			.S (fifo[depth]),
			.CO(coT[0])
		);

		// each stage adds one new bit and one carry to the running sum
		for (genvar i = 1; i < depth - 2; i++) begin : stage
			FullAdder fa (
				.A (fifo[i+2]),
				.B (fifo[depth+2*(i-1)+1]),
				.CI(fifo[depth+2*(i-1)]),
				.S (fifo[depth+2*i]),
				.CO(coT[i])
			);
		end
	end else begin : tree
		// take three from the front and push sum to the back
		for (genvar i = 0; i < depth - 2; i++) begin : node
			FullAdder fa (
				.A (fifo[3*i]),
				.B (fifo[3*i+1]),
				.CI(fifo[3*i+2]),
				.S (fifo[depth+2*i]),
				.CO(coT[i])
			);
		end
	end

	assign S = fifo[3*depth-6]; // sum of the last adder
	assign C = coT[depth-3];
	assign CO = coT[depth-4:0];

endmodule

module AddMopCsv #(
	parameter int width = 8, // word width
	parameter int depth = 4, // operand count
	parameter int speed = 2
) (
	input  logic [depth*width-1:0] A, // operand k in slice k
	output logic [width-1:0]       S, // sum vector
	output logic [width-1:0]       C  // carry vector already shifted
);

	logic [depth*width-1:0]         byWeight; // bits grouped per weight
	logic [(depth-3)*(width+1)-1:0] ciChain;  // carries between slices
	logic [width-1:0]               cRaw;     // unshifted

	always_comb begin
		for (int i = 0; i < width; i++) begin
			for (int k = 0; k < depth; k++) begin
				byWeight[i*depth+k] = A[k*width+i];
			end
		end
	end

	assign ciChain[depth-4:0] = '0; // nothing below bit 0

	for (genvar i = 0; i < width; i++) begin : slice
		Cpr #(
			.depth(depth),
			.speed(speed)
		) cpr (
			.A (byWeight[i*depth +: depth]),
			.CI(ciChain[i*(depth-3) +: depth-3]),
			.S (S[i]),
			.C (cRaw[i]),
			.CO(ciChain[(i+1)*(depth-3) +: depth-3])
		);
	end

	// top carries fall off modulo 2^width
	assign C = {cRaw[width-2:0], 1'b0};

endmodule

// File: mulLane/mulLane.sv
`timescale 1ns/100ps
`include "arith_defines.svh"

module AddMulPPGenUns #(
	parameter int widthX = 8, // XS and XC
	parameter int widthY = 8  // Y
) (
	input  logic [widthX-1:0]                 XS,
	input  logic [widthX-1:0]                 XC,
	input  logic [widthY-1:0]                 Y,
	output logic [widthX*(widthX+widthY)-1:0] PP // one row per digit
);

	localparam int widthP = widthX + widthY;

	logic [widthX-1:0] one, two; // digit equals 1 or 2
	logic [widthY+1:0] yExt;     // Y with a zero on each side

	assign one = XS ^ XC;
	assign two = XS & XC;
	assign yExt = {1'b0, Y, 1'b0};

	// row i holds digit_i * Y shifted by i
	always_comb begin
		PP = '0;
		for (int i = 0; i < widthX; i++) begin
			for (int k = 0; k <= widthY; k++) begin
				PP[i*widthP+i+k] = (one[i] & yExt[k+1]) | (two[i] & yExt[k]); // Y or 2Y
			end
		end
	end

endmodule

module AddMulUns #(
	parameter int widthX = 8,
	parameter int widthY = 8,
	parameter int speed = 2
) (
	input  logic [widthX-1:0]        XS,
	input  logic [widthX-1:0]        XC,
	input  logic [widthY-1:0]        Y,
	output logic [widthX+widthY-1:0] P // (XS+XC)*Y
);

	logic [widthX*(widthX+widthY)-1:0] pp;
	logic [widthX+widthY-1:0]          sumT, carryT;

	AddMulPPGenUns #(.widthX(widthX), .widthY(widthY)) ppGen (.XS(XS), .XC(XC), .Y(Y), .PP(pp));

	// compress widthX rows to a carry-save pair
	AddMopCsv #(.width(widthX + widthY), .depth(widthX), .speed(speed)) csvAdd (
		.A(pp),
		.S(sumT),
		.C(carryT)
	);

	Add #(.width(widthX + widthY), .speed(speed)) cpAdd (.A(sumT), .B(carryT), .S(P));

endmodule

module mulLane (
	input  logic                clk,
	input  logic                rstN,
	input  logic                laneValid,
	input  arithPkg::operandX_t laneXs,
	input  arithPkg::operandX_t laneXc,
	input  arithPkg::coef_t     laneY,
	output logic                prodValid,
	output arithPkg::product_t  prod
);

	arithPkg::product_t prodNext; // combinational product

	AddMulUns #(.widthX(`WIDTH_X), .widthY(`WIDTH_Y), .speed(`SPEED)) mul (
		.XS(laneXs),
		.XC(laneXc),
		.Y (laneY),
		.P (prodNext)
	);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			prodValid <= 1'b0;
		end else begin
			prodValid <= laneValid;
		end
	end

	always_ff @(posedge clk) begin
		if (laneValid) begin
			prod <= prodNext; // hold between strobes
		end
	end

endmodule

// File: hw/operandLoader.sv
`timescale 1ns/100ps
`include "arith_defines.svh"

module operandLoader (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic                             coefWrite, // host write strobe
	input  arithPkg::laneIdx_t               coefIndex,
	input  arithPkg::coef_t                  coefData,
	input  logic                             opStrobe,
	input  arithPkg::operandX_t [`LANES-1:0] opSum,   // lane k in slice k
	input  arithPkg::operandX_t [`LANES-1:0] opCarry,
	output logic                [`LANES-1:0] laneValid,
	output arithPkg::operandX_t [`LANES-1:0] laneXs,
	output arithPkg::operandX_t [`LANES-1:0] laneXc,
	output arithPkg::coef_t     [`LANES-1:0] laneY
);

	arithPkg::coef_t [`LANES-1:0] coefBank;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			coefBank <= '0; // unwritten lanes contribute nothing
			laneValid <= '0;
		end else begin
			if (coefWrite && (coefIndex < `LANES)) begin
				coefBank[coefIndex] <= coefData;
			end
			laneValid <= {`LANES{opStrobe}}; // all lanes in lockstep
		end
	end

	// bank is sampled before this edge's write lands
	always_ff @(posedge clk) begin
		if (opStrobe) begin
			laneXs <= opSum;
			laneXc <= opCarry;
			laneY <= coefBank;
		end
	end

	// host keeps the bank untouched until reset is released
	noWriteInReset: assert property (@(posedge clk) !rstN |-> !coefWrite)
		else $error("coefficient write while in reset");

endmodule

// File: hw/laneReducer.sv
`timescale 1ns/100ps
`include "arith_defines.svh"

module laneReducer (
	input  logic                            clk,
	input  logic                            rstN,
	input  logic               [`LANES-1:0] prodValid,
	input  arithPkg::product_t [`LANES-1:0] prod,
	output logic                            outValid,
	output arithPkg::dotSum_t               outSum
);

	localparam int sumW = $bits(arithPkg::dotSum_t);
	localparam int csvDepth = (`LANES < 4) ? 4 : `LANES; // compressor wants four rows

	logic [csvDepth*sumW-1:0] rows;
	logic [sumW-1:0]          rowS, rowC; // carry-save pair
	arithPkg::dotSum_t        sumNext;

	always_comb begin
		rows = '0; // padding rows stay zero
		for (int k = 0; k < `LANES; k++) begin
			rows[k*sumW +: sumW] = arithPkg::dotSum_t'(prod[k]); // zero extend
		end
	end

	if (`LANES < 3) begin : direct
		assign rowS = rows[0 +: sumW];
		assign rowC = rows[sumW +: sumW];
	end else begin : tree
		AddMopCsv #(.width(sumW), .depth(csvDepth), .speed(`SPEED)) csvAdd (
			.A(rows),
			.S(rowS),
			.C(rowC)
		);
	end

	Add #(.width(sumW), .speed(`SPEED)) finalAdd (.A(rowS), .B(rowC), .S(sumNext));

	always_ff @(posedge clk) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= prodValid[0]; // lane 0 speaks for all
		end
	end

	always_ff @(posedge clk) begin
		if (prodValid[0]) begin
			outSum <= sumNext;
		end
	end

	// loader fires every lane together so the lanes never drift apart
	lanesInStep: assert property (@(posedge clk) disable iff (!rstN)
		(prodValid == '0) || (prodValid == '1));

	validKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(outValid));

endmodule

// File: hw/dotEngine.sv
`timescale 1ns/100ps
`include "arith_defines.svh"

module dotEngine (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic                             coefWrite,
	input  arithPkg::laneIdx_t               coefIndex,
	input  arithPkg::coef_t                  coefData,
	input  logic                             opStrobe,
	input  arithPkg::operandX_t [`LANES-1:0] opSum,
	input  arithPkg::operandX_t [`LANES-1:0] opCarry,
	output logic                             outValid, // one cycle per result
	output arithPkg::dotSum_t                outSum
);

	logic                [`LANES-1:0] laneValid; // loader to lanes
	arithPkg::operandX_t [`LANES-1:0] laneXs;
	arithPkg::operandX_t [`LANES-1:0] laneXc;
	arithPkg::coef_t     [`LANES-1:0] laneY;
	logic                [`LANES-1:0] prodValid; // lanes to reducer
	arithPkg::product_t  [`LANES-1:0] prod;

	operandLoader loader (
		.clk(clk), .rstN(rstN),
		.coefWrite(coefWrite), .coefIndex(coefIndex), .coefData(coefData),
		.opStrobe(opStrobe), .opSum(opSum), .opCarry(opCarry),
		.laneValid(laneValid), .laneXs(laneXs), .laneXc(laneXc), .laneY(laneY)
	);

	for (genvar k = 0; k < `LANES; k++) begin : lanes
		mulLane lane (
			.clk(clk), .rstN(rstN),
			.laneValid(laneValid[k]), .laneXs(laneXs[k]), .laneXc(laneXc[k]), .laneY(laneY[k]),
			.prodValid(prodValid[k]), .prod(prod[k])
		);
	end

	laneReducer reducer (
		.clk(clk), .rstN(rstN),
		.prodValid(prodValid), .prod(prod),
		.outValid(outValid), .outSum(outSum)
	);

endmodule

// File: verification/tbDotEngine.sv
`timescale 1ns/100ps
`include "arith_defines.svh"

module tbDotEngine;

	logic                             clk;
	logic                             rstN;
	logic                             coefWrite;
	arithPkg::laneIdx_t               coefIndex;
	arithPkg::coef_t                  coefData;
	logic                             opStrobe;
	arithPkg::operandX_t [`LANES-1:0] opSum;
	arithPkg::operandX_t [`LANES-1:0] opCarry;
	logic                             outValid;
	arithPkg::dotSum_t                outSum;

	arithPkg::coef_t bankModel [`LANES]; // model copy of the coefficient bank
	logic [31:0]     lcgState = 32'h6064912c;

	dotEngine i_dotEngine (
		.clk(clk), .rstN(rstN),
		.coefWrite(coefWrite), .coefIndex(coefIndex), .coefData(coefData),
		.opStrobe(opStrobe), .opSum(opSum), .opCarry(opCarry),
		.outValid(outValid), .outSum(outSum)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// sum over lanes of (xs+xc)*y
	function automatic arithPkg::dotSum_t refDot(input arithPkg::operandX_t [`LANES-1:0] xs,
			input arithPkg::operandX_t [`LANES-1:0] xc);
		longint acc;
		acc = 0;
		for (int k = 0; k < `LANES; k++) begin
			acc += (longint'(xs[k]) + longint'(xc[k])) * longint'(bankModel[k]);
		end
		return arithPkg::dotSum_t'(acc);
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(input string testName, input arithPkg::dotSum_t expected,
			input arithPkg::dotSum_t actual);
		assert (actual === expected) else
			abortRun($sformatf("ERROR %s expected %0d actual %0d", testName, expected, actual));
	endtask

	task automatic stepCycle();
		@(posedge clk);
		#2; // drive slot
	endtask

	// xc masked by ~xs so the halves never carry past WIDTH_X
	task automatic randOperands(output arithPkg::operandX_t [`LANES-1:0] xs,
			output arithPkg::operandX_t [`LANES-1:0] xc);
		for (int k = 0; k < `LANES; k++) begin
			xs[k] = nextRand() >> 7;
			xc[k] = (nextRand() >> 11) & ~xs[k];
		end
	endtask

	task automatic writeCoef(input int idx, input arithPkg::coef_t data);
		coefWrite = 1'b1;
		coefIndex = arithPkg::laneIdx_t'(idx);
		coefData = data;
		bankModel[idx] = data;
		stepCycle();
		coefWrite = 1'b0;
	endtask

	task automatic sendStrobe(input arithPkg::operandX_t [`LANES-1:0] xs,
			input arithPkg::operandX_t [`LANES-1:0] xc);
		opStrobe = 1'b1;
		opSum = xs;
		opCarry = xc;
		stepCycle();
		opStrobe = 1'b0;
	endtask

	task automatic waitResult(input string testName, input arithPkg::dotSum_t expected);
		int n;
		n = 0;
		do begin
			@(posedge clk);
			#1; // outputs settled
			n++;
		end while (!outValid && n < 20);
		assert (outValid === 1'b1) else
			abortRun($sformatf("%s: outValid never came within 20 cycles", testName));
		checkValue(testName, expected, outSum);
		#1;
	endtask

	task automatic testReset();
		arithPkg::operandX_t [`LANES-1:0] xs, xc;
		for (int i = 0; i < 5; i++) begin
			@(posedge clk);
			#1;
			assert (outValid === 1'b0) else
				abortRun($sformatf("ERROR testReset expected 0 actual %b", outValid));
			#1;
		end
		randOperands(xs, xc);
		sendStrobe(xs, xc);
		waitResult("testReset", '0); // bank still all zero
	endtask

	task automatic testSingleLane();
		arithPkg::operandX_t [`LANES-1:0] xs, xc;
		for (int k = 0; k < `LANES; k++) begin
			writeCoef(k, (k == 2) ? 8'd255 : 8'd0);
		end
		randOperands(xs, xc);
		xs[2] = 8'd200; // largest allowed sum, 255
		xc[2] = 8'd55;
		sendStrobe(xs, xc);
		waitResult("testSingleLane", refDot(xs, xc));
		randOperands(xs, xc);
		sendStrobe(xs, xc);
		waitResult("testSingleLane", refDot(xs, xc));
	endtask

	task automatic testCarrySave();
		arithPkg::operandX_t [`LANES-1:0] v, xs, xc;
		arithPkg::dotSum_t firstSum;
		for (int k = 0; k < `LANES; k++) begin
			writeCoef(k, arithPkg::coef_t'(nextRand() >> 5));
			v[k] = nextRand() >> 9;
		end
		for (int s = 0; s < 4; s++) begin
			for (int k = 0; k < `LANES; k++) begin
				case (s)
					0: xs[k] = v[k];      // xc zero
					1: xs[k] = '0;        // xs zero
					2: xs[k] = v[k] >> 1;
					default: xs[k] = (nextRand() >> 13) & v[k];
				endcase
				xc[k] = v[k] - xs[k];
			end
			sendStrobe(xs, xc);
			waitResult("testCarrySave", refDot(xs, xc));
			if (s == 0) begin
				firstSum = outSum;
			end else begin
				checkValue("testCarrySave", firstSum, outSum); // same for every split
			end
		end
	endtask

	task automatic testBackToBack();
		arithPkg::operandX_t [`LANES-1:0] xs, xc;
		arithPkg::dotSum_t expSum [16];
		int got;
		got = 0;
		for (int k = 0; k < `LANES; k++) begin
			writeCoef(k, arithPkg::coef_t'(nextRand() >> 3));
		end
		// strobe j goes out in pass j and must show up in pass j+3
		for (int c = 0; c < 24; c++) begin
			@(posedge clk);
			#1;
			if (outValid) begin
				assert (got < 16 && c == got + 3) else
					abortRun($sformatf(
						"ERROR testBackToBack expected result %0d at cycle %0d actual cycle %0d",
						got, got + 3, c));
				checkValue("testBackToBack", expSum[got], outSum);
				got++;
			end
			#1;
			if (c < 16) begin
				randOperands(xs, xc);
				expSum[c] = refDot(xs, xc);
				opStrobe = 1'b1;
				opSum = xs;
				opCarry = xc;
			end else begin
				opStrobe = 1'b0;
			end
		end
		assert (got == 16) else
			abortRun($sformatf("ERROR testBackToBack expected 16 results actual %0d", got));
	endtask

	task automatic testCoefUpdate();
		arithPkg::operandX_t [`LANES-1:0] xs, xc;
		arithPkg::dotSum_t oldSum;
		for (int k = 0; k < `LANES; k++) begin
			writeCoef(k, arithPkg::coef_t'(8'd17 * (k + 1)));
		end
		randOperands(xs, xc);
		xs[1] = 8'd100;
		xc[1] = 8'd20;
		oldSum = refDot(xs, xc); // strobe sees the bank before the write
		coefWrite = 1'b1;
		coefIndex = arithPkg::laneIdx_t'(1);
		coefData = 8'd201;
		bankModel[1] = 8'd201;
		sendStrobe(xs, xc);
		coefWrite = 1'b0;
		waitResult("testCoefUpdate", oldSum);
		sendStrobe(xs, xc);
		waitResult("testCoefUpdate", refDot(xs, xc));
	endtask

	initial begin
		rstN = 1'b0;
		coefWrite = 1'b0;
		coefIndex = '0;
		coefData = '0;
		opStrobe = 1'b0;
		opSum = '0;
		opCarry = '0;
		for (int k = 0; k < `LANES; k++) begin
			bankModel[k] = '0; // bank resets to zero
		end
		repeat (2) @(posedge clk);
		#2 rstN = 1'b1;
		testReset();
		testSingleLane();
		testCarrySave();
		testBackToBack();
		testCoefUpdate();
		$display(">>> PASS");
		$finish;
	end

endmodule

// File: all.f
+incdir+common
common/arithPkg.sv
hw/prefixAdder.sv
hw/csvCompressor.sv
mulLane/mulLane.sv
hw/operandLoader.sv
hw/laneReducer.sv
hw/dotEngine.sv
verification/tbDotEngine.sv
